//--- uartTxTop.f
hw/uartPkg.sv
hw/uartTxRegs.sv
hw/uartBaudGen.sv
hw/uartTxFifo.sv
hw/uartTransmitter.sv
hw/uartTxTop.sv
bench/uartTxTb.sv

//--- bench/uartTxTb.sv
/*
 * testbench for the uart transmit peripheral
 * clock and reset, lfsr byte source, host write tasks
 * serial line decoder, reference line function, compare process
 * cycle watchdog
 */
`timescale 1ns/100ps
`default_nettype none

module uartTxTb;

	localparam int totalFrames = 35;	// 4 + 10 + 17 + 4 frames on the line
	localparam int maxDiv      = 63;	// largest divisor used
	localparam int cycleLimit  = (3 * totalFrames * (10 + 1) * 16 * (maxDiv + 1)) / 2;

	logic                 clk;
	logic                 reset;
	uartPkg::hostWrite_t  hostWr;
	logic                 tx;
	uartPkg::uartStatus_t status;

	logic [31:0]        lfsr;		// byte source state
	int                 curDiv;		// divisor as programmed
	int                 errors;
	int                 framesChecked;
	int                 cycles;
	uartPkg::uartData_t expQ[$];	// bytes still due on tx
	logic [9:0]         rxFrames[$];	// sampled frames, bit 0 is start

	uartTxTop i_dut (
		.clk(clk), .reset(reset), .hostWr(hostWr), .tx(tx), .status(status)
	);

	always #20 clk = ~clk;	// 40 ns period

	////////////////////////////////////////////////////////////
	// helpers

	// 32 bit fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// expected line level per frame bit index
	function automatic logic expectedLine(input uartPkg::uartData_t b, input int idx);
		if (idx == 0)
			return 1'b0;	// start
		else if (idx <= 8)
			return b[idx-1];	// lsb first
		else
			return 1'b1;	// stop
	endfunction

	task automatic checkValue(input logic [31:0] got, input logic [31:0] want,
		input string what);
		if (got !== want)
		begin
			errors++;
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, want);
		end
	endtask

	task automatic nextByte(output uartPkg::uartData_t b);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsrStep(lfsr);	// one step per bit
			b[i] = lfsr[0];
		end
	endtask

	// strobe stays up until endWrite, so calls chain back to back
	task automatic writeReg(input uartPkg::regAddr_t addr, input logic [15:0] data);
		@(posedge clk);
		hostWr.en   <= 1'b1;
		hostWr.addr <= addr;
		hostWr.data <= data;
		if (addr == uartPkg::regBaudDiv)
			curDiv = data;	// decoder bit time
	endtask

	task automatic endWrite();
		@(posedge clk);
		hostWr.en <= 1'b0;
	endtask

	task automatic sendByte(input logic keep);
		uartPkg::uartData_t b;
		nextByte(b);
		writeReg(uartPkg::regTxData, {8'h00, b});
		if (keep)
			expQ.push_back(b);	// dropped bytes never expected
	endtask

	// all bytes out and checked, transmitter back in idle
	task automatic waitIdle();
		@(negedge clk);
		while (expQ.size() != 0 || rxFrames.size() != 0 || status.busy || !status.fifoEmpty)
			@(negedge clk);
	endtask

	////////////////////////////////////////////////////////////
	// serial line decoder, samples at bit middles from the start edge
	initial
	begin : decoder
		logic [9:0] frame;
		int bitCycles;
		@(negedge reset);
		forever
		begin
			@(negedge clk);
			if (tx === 1'b0)
			begin
				bitCycles = 16 * (curDiv + 1);
				repeat (bitCycles / 2) @(negedge clk);	// middle of start bit
				for (int k = 0; k < 10; k++)
				begin
					frame[k] = tx;
					if (k < 9)
						repeat (bitCycles) @(negedge clk);
				end
				rxFrames.push_back(frame);
			end
		end
	end

	// compare each decoded frame against the next expected byte
	initial
	begin : compare
		logic [9:0] frame;
		uartPkg::uartData_t want;
		forever
		begin
			@(negedge clk);
			if (rxFrames.size() > 0)
			begin
				frame = rxFrames.pop_front();
				if (expQ.size() == 0)
				begin
					errors++;
					$display("frame %03h appeared on tx at %0t with no byte pending", frame, $time);
				end
				else
				begin
					want = expQ.pop_front();
					for (int k = 0; k < 10; k++)
						checkValue(frame[k], expectedLine(want, k), $sformatf("frame bit %0d", k));
					checkValue(frame[8:1], want, "received byte");
					framesChecked++;
				end
			end
		end
	end

	// watchdog
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycleLimit)
		begin
			$display("transmitter stalled, no finish within %0d cycles", cycleLimit);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// main sequence
	initial
	begin
		clk           = 1'b0;
		reset         = 1'b1;
		hostWr        = '0;
		lfsr          = 32'd82248;
		curDiv        = 1;	// reset divisor
		errors        = 0;
		framesChecked = 0;
		cycles        = 0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);

		// idle after reset
		checkValue(tx, 1'b1, "tx after reset");
		checkValue(status.busy, 1'b0, "busy after reset");
		checkValue(status.fifoEmpty, 1'b1, "fifoEmpty after reset");
		checkValue(status.fifoFull, 1'b0, "fifoFull after reset");
		checkValue(status.count, 0, "count after reset");
		checkValue(status.overflow, 1'b0, "overflow after reset");

		// single bytes, divisor 1
		repeat (4)
		begin
			sendByte(1'b1);
			endWrite();
			waitIdle();
		end

		// ten back to back, first goes straight to the transmitter
		repeat (10) sendByte(1'b1);
		endWrite();
		repeat (2) @(negedge clk);
		checkValue(status.count, 9, "count after burst");
		checkValue(status.busy, 1'b1, "busy during burst");
		while (expQ.size() != 0)
			@(negedge clk);
		checkValue(status.busy, 1'b1, "busy in last stop bit");	// last frame decoded mid stop
		waitIdle();
		checkValue(status.count, 0, "count after drain");
		checkValue(tx, 1'b1, "tx after drain");

		////////////////////////////////////////////////////////////
		// fill and overflow behind a slow line
		writeReg(uartPkg::regBaudDiv, 16'(maxDiv));
		endWrite();
		repeat (2 * (maxDiv + 1)) @(negedge clk);	// old tick period runs out
		sendByte(1'b1);
		endWrite();
		while (!status.busy)
			@(negedge clk);
		repeat (16) sendByte(1'b1);	// fills all 16 slots
		sendByte(1'b0);	// no room, dropped
		endWrite();
		repeat (2) @(negedge clk);
		checkValue(status.count, 16, "count when full");
		checkValue(status.fifoFull, 1'b1, "fifoFull");
		checkValue(status.overflow, 1'b1, "overflow on 17th write");
		repeat (100) @(negedge clk);
		checkValue(status.overflow, 1'b1, "overflow held");
		writeReg(uartPkg::regClearStat, 16'h0000);
		endWrite();
		@(negedge clk);
		checkValue(status.overflow, 1'b0, "overflow after clear");
		waitIdle();
		checkValue(status.overflow, 1'b0, "overflow after drain");

		// divisor 3, 64 cycle bits
		writeReg(uartPkg::regBaudDiv, 16'd3);
		endWrite();
		repeat (2 * (maxDiv + 1)) @(negedge clk);
		repeat (4) sendByte(1'b1);
		endWrite();
		waitIdle();

		checkValue(framesChecked, totalFrames, "frames checked");
		$display("errors: %0d, frames checked: %0d", errors, framesChecked);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- hw/uartTxTop.sv
/*
 * uart transmit peripheral top level
 * config block, baud generator, tx fifo and transmitter
 */
`timescale 1ns/100ps
`default_nettype none

module uartTxTop #(
	parameter int dataBits      = 8,
	parameter int sbTick        = 16,	// one stop bit
	parameter int fifoDepthLog2 = 4	// 16 entries
) (
	input  wire                  clk,
	input  wire                  reset,
	input  uartPkg::hostWrite_t  hostWr,
	output logic                 tx,
	output uartPkg::uartStatus_t status
);

	logic                pushEn;
	uartPkg::uartData_t  pushData;
	uartPkg::baudDiv_t   baudDiv;
	logic                sTick;
	logic                popEn;		// from txDoneTick
	uartPkg::uartData_t  headData;
	logic                fifoFull;
	logic                fifoEmpty;
	uartPkg::fifoCount_t count;
	logic                busy;
	logic                txReq;		// fifo has a byte

	assign txReq = ~fifoEmpty;

	uartTxRegs #(.fifoDepthLog2(fifoDepthLog2)) i_regs (
		.clk(clk), .reset(reset), .hostWr(hostWr),
		.fifoFull(fifoFull), .fifoEmpty(fifoEmpty), .busy(busy), .count(count),
		.pushEn(pushEn), .pushData(pushData), .baudDiv(baudDiv), .status(status)
	);

	uartBaudGen i_baudGen (
		.clk(clk), .reset(reset), .baudDiv(baudDiv), .sTick(sTick)
	);

	uartTxFifo #(.fifoDepthLog2(fifoDepthLog2)) i_fifo (
		.clk(clk), .reset(reset), .pushEn(pushEn), .pushData(pushData),
		.popEn(popEn), .headData(headData), .full(fifoFull), .empty(fifoEmpty),
		.count(count)
	);

	uartTransmitter #(.dataBits(dataBits), .sbTick(sbTick)) i_transmitter (
		.clk(clk), .reset(reset), .sTick(sTick), .txStart(txReq), .din(headData),
		.tx(tx), .txDoneTick(popEn), .busy(busy)
	);

endmodule

`default_nettype wire

//--- hw/uartTransmitter.sv
/*
 * uart transmit fsm: idle, start, data, stop
 * one start bit, dataBits bits lsb first, sbTick ticks of stop
 * pops the fifo and latches the head byte when leaving idle
 */
`timescale 1ns/100ps
`default_nettype none

module uartTransmitter #(
	parameter int dataBits = 8,
	parameter int sbTick   = 16	// 16, 24, 32 for 1, 1.5, 2 stop bits
) (
	input  wire                clk,
	input  wire                reset,
	input  wire                sTick,
	input  wire                txStart,
	input  uartPkg::uartData_t din,
	output logic               tx,
	output logic               txDoneTick,
	output logic               busy
);

	localparam int tickW = $clog2(sbTick);	// holds 0..sbTick-1, at least 15
	localparam int bitW  = $clog2(dataBits);

	uartPkg::txState_t      stateReg, stateNext;
	logic [tickW-1:0]       sReg, sNext;	// oversample ticks in bit
	logic [bitW-1:0]        nReg, nNext;	// data bit index
	logic [dataBits-1:0]    bReg, bNext;	// shift register
	logic                   txReg, txNext;

	////////////////////////////////////////////////////////////
	// state registers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= uartPkg::txIdle;
			sReg     <= '0;
			nReg     <= '0;
			bReg     <= '0;
			txReg    <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg     <= sNext;
			nReg     <= nNext;
			bReg     <= bNext;
			txReg    <= txNext;
		end
	end

	////////////////////////////////////////////////////////////
	// next state
	always_comb
	begin
		stateNext  = stateReg;
		sNext      = sReg;
		nNext      = nReg;
		bNext      = bReg;
		txNext     = txReg;
		txDoneTick = 1'b0;
		case (stateReg)
			uartPkg::txIdle:
			begin
				txNext = 1'b1;
				if (txStart)
				begin
					txDoneTick = 1'b1;	// fifo read
					bNext      = din[dataBits-1:0];	// head byte, same cycle as pop
					sNext      = '0;
					stateNext  = uartPkg::txStart;
				end
			end
			uartPkg::txStart:
			begin
				txNext = 1'b0;	// start bit
				if (sTick)
				begin
					if (sReg == tickW'(15))
					begin
						sNext     = '0;
						nNext     = '0;
						stateNext = uartPkg::txData;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::txData:
			begin
				txNext = bReg[0];	// lsb first
				if (sTick)
				begin
					if (sReg == tickW'(15))
					begin
						sNext = '0;
						bNext = bReg >> 1;
						if (nReg == bitW'(dataBits - 1))
							stateNext = uartPkg::txStop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			uartPkg::txStop:
			begin
				txNext = 1'b1;
				if (sTick)
				begin
					if (sReg == tickW'(sbTick - 1))
						stateNext = uartPkg::txIdle;	// one idle cycle before next frame
					else
						sNext = sReg + 1'b1;
				end
			end
			default: stateNext = uartPkg::txIdle;
		endcase
	end

	assign tx   = txReg;
	assign busy = (stateReg != uartPkg::txIdle);

endmodule

`default_nettype wire

//--- hw/uartTxFifo.sv
/*
 * show-ahead transmit fifo
 * circular buffer, head byte always on headData
 * occupancy count, full and empty levels
 */
`timescale 1ns/100ps
`default_nettype none

module uartTxFifo #(
	parameter int fifoDepthLog2 = 4
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 pushEn,
	input  uartPkg::uartData_t  pushData,
	input  wire                 popEn,
	output uartPkg::uartData_t  headData,
	output logic                full,
	output logic                empty,
	output uartPkg::fifoCount_t count
);

	localparam int depth = 1 << fifoDepthLog2;

	uartPkg::uartData_t mem [0:depth-1];	// byte storage

	logic [fifoDepthLog2-1:0] wrPtr;
	logic [fifoDepthLog2-1:0] rdPtr;
	logic [fifoDepthLog2:0]   level;	// one bit wider, holds depth

	logic doPush;
	logic doPop;

	// a pop frees a slot, so push while full is fine then
	assign doPush = pushEn && (!full || popEn);
	assign doPop  = popEn && !empty;

	////////////////////////////////////////////////////////////
	// storage write
	always_ff @(posedge clk)
		if (doPush)
			mem[wrPtr] <= pushData;

	// pointers and level
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// wraps at depth
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;	// none, or both
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// outputs
	assign headData = mem[rdPtr];	// show-ahead
	assign full     = (level == depth[fifoDepthLog2:0]);
	assign empty    = (level == '0);
	assign count    = uartPkg::fifoCount_t'(level);

endmodule

`default_nettype wire

//--- hw/uartBaudGen.sv
/*
 * baud tick generator
 * one clock sTick pulse every baudDiv+1 cycles, 16 per bit
 */
`timescale 1ns/100ps
`default_nettype none

module uartBaudGen (
	input  wire               clk,
	input  wire               reset,
	input  uartPkg::baudDiv_t baudDiv,
	output logic              sTick
);

	uartPkg::baudDiv_t cnt;	// down counter

	////////////////////////////////////////////////////////////
	// reload on zero, new divisor picked up here
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt   <= '0;
			sTick <= 1'b0;
		end
		else if (cnt == '0)
		begin
			cnt   <= baudDiv;
			sTick <= 1'b1;	// one cycle pulse
		end
		else
		begin
			cnt   <= cnt - 1'b1;
			sTick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hw/uartTxRegs.sv
/*
 * configuration block of the uart transmitter
 * baud divisor register, sticky overflow flag
 * registered fifo push from host writes, status packing
 */
`timescale 1ns/100ps
`default_nettype none

module uartTxRegs #(
	parameter int fifoDepthLog2 = 4
) (
	input  wire                  clk,
	input  wire                  reset,
	input  uartPkg::hostWrite_t  hostWr,
	input  wire                  fifoFull,
	input  wire                  fifoEmpty,
	input  wire                  busy,
	input  uartPkg::fifoCount_t  count,
	output logic                 pushEn,
	output uartPkg::uartData_t   pushData,
	output uartPkg::baudDiv_t    baudDiv,
	output uartPkg::uartStatus_t status
);

	// count one below full, a pending push fills the last slot
	localparam uartPkg::fifoCount_t lastSlot =
		uartPkg::fifoCount_t'((1 << fifoDepthLog2) - 1);

	logic overflow;
	logic wrData;		// host write to the data register
	logic noRoom;		// fifo full, or about to be

	assign wrData = hostWr.en && (hostWr.addr == uartPkg::regTxData);
	assign noRoom = fifoFull || (pushEn && (count == lastSlot));

	// push pipeline, one cycle behind the host strobe
	always_ff @(posedge clk or posedge reset)
		if (reset)
			pushEn <= 1'b0;
		else
			pushEn <= wrData && !noRoom;

	always_ff @(posedge clk)
		if (wrData)
			pushData <= hostWr.data[7:0];	// low byte of the write

	// divisor and overflow
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			baudDiv  <= uartPkg::baudDiv_t'(1);
			overflow <= 1'b0;
		end
		else
		begin
			if (hostWr.en && (hostWr.addr == uartPkg::regBaudDiv))
				baudDiv <= uartPkg::baudDiv_t'(hostWr.data);
			if (wrData && noRoom)
				overflow <= 1'b1;	// byte dropped
			else if (hostWr.en && (hostWr.addr == uartPkg::regClearStat))
				overflow <= 1'b0;
		end
	end

	// continuous status level
	assign status = '{busy: busy, fifoFull: fifoFull, fifoEmpty: fifoEmpty,
		overflow: overflow, count: count};

endmodule

`default_nettype wire

//--- hw/uartPkg.sv
/*
 * shared types for the uart transmit peripheral
 * width typedefs, host register map, transmitter states
 * host write bundle and status word
 */
`default_nettype none

package uartPkg;

	////////////////////////////////////////////////////////////
	// widths with a meaning
	typedef logic [7:0]  uartData_t;	// one transmit byte, matches dataBits default
	typedef logic [15:0] baudDiv_t;		// tick every divisor+1 clocks
	typedef logic [4:0]  fifoCount_t;	// 0..16 at default depth

	// host register addresses
	typedef enum logic [1:0] {
		regTxData    = 2'd0,	// push a byte
		regBaudDiv   = 2'd1,	// load divisor
		regClearStat = 2'd2	// clear overflow
	} regAddr_t;

	// transmitter fsm
	typedef enum logic [1:0] {txIdle, txStart, txData, txStop} txState_t;

	////////////////////////////////////////////////////////////
	// host write strobe with address and value
	typedef struct packed {
		logic        en;
		regAddr_t    addr;
		logic [15:0] data;	// byte writes use low 8 bits
	} hostWrite_t;

	typedef struct packed {
		logic       busy;
		logic       fifoFull;
		logic       fifoEmpty;
		logic       overflow;	// sticky until regClearStat
		fifoCount_t count;
	} uartStatus_t;

endpackage

`default_nettype wire
